//--- src/rs_pkg.sv
package rs_pkg;

  localparam int TAG_W    = 8;   // Physical register tag.
  localparam int PC_W     = 32;
  localparam int OP_W     = 4;
  localparam int RS_DEPTH = 8;   // Entries per station.

  // Broadcast ports: ALU, mul/div, load, branch/CSR.
  localparam int NUM_WB   = 4;

  typedef logic [TAG_W-1:0] tag_t;

  // One result broadcast.
  typedef struct packed {
    logic valid;
    tag_t tag;
  } wb_t;

  typedef wb_t [NUM_WB-1:0] wb_bus_t;

  // Both source operands of an operation, as tags with ready bits.
  typedef struct packed {
    tag_t tag1;
    logic rdy1;
    tag_t tag2;
    logic rdy2;
  } src_t;

  typedef struct packed {
    logic [PC_W-1:0] pc;
    tag_t            rd;
    logic [OP_W-1:0] op;
    logic            high;  // Upper half of the product.
  } mul_payload_t;

  typedef struct packed {
    logic [PC_W-1:0] pc;
    tag_t            rd;
    logic [OP_W-1:0] op;
    logic            is_signed;
    logic            rem;  // Remainder instead of quotient.
  } div_payload_t;

  // Operation handed to the shared multiply/divide unit.
  typedef struct packed {
    logic            valid;
    logic            unit;    // 0 multiply, 1 divide.
    logic [PC_W-1:0] pc;
    tag_t            rd;
    logic [OP_W-1:0] op;
    logic            flag_a;  // high or is_signed.
    logic            flag_b;  // 0 or rem.
    tag_t            src1;
    tag_t            src2;
  } issue_t;

endpackage

//--- src/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  parameter type payload_t = rs_pkg::mul_payload_t,
  parameter int  DEPTH     = rs_pkg::RS_DEPTH
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            flush,
  input  logic            disp_valid,
  input  payload_t        disp_payload,
  input  rs_pkg::src_t    disp_src,
  input  rs_pkg::wb_bus_t wb,
  output logic            full,
  output logic            req,
  output payload_t        req_payload,
  output rs_pkg::src_t    req_src,
  input  logic            grant
);

  logic [DEPTH-1:0] busy;
  payload_t         payload_q [DEPTH];
  rs_pkg::src_t     src_q [DEPTH];
  logic [DEPTH-1:0] ready_vec;  // Busy with both sources ready.
  logic [DEPTH-1:0] req_oh;
  logic [DEPTH-1:0] free_oh;
  rs_pkg::src_t     disp_entry;

  // True when any valid broadcast carries this tag.
  function automatic logic wb_hit(input rs_pkg::tag_t tag, input rs_pkg::wb_bus_t bus);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < rs_pkg::NUM_WB; p++) begin
      hit |= bus[p].valid && (bus[p].tag == tag);
    end
    return hit;
  endfunction

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready_vec[i] = busy[i] & src_q[i].rdy1 & src_q[i].rdy2;
    end
  end

  // Lowest set bit of ready_vec, lowest clear bit of busy.
  assign req_oh  = ready_vec & (~ready_vec + 1'b1);
  assign free_oh = ~busy & (busy + 1'b1);

  assign req  = |ready_vec;
  assign full = &busy;

  always_comb begin
    req_payload = payload_q[0];
    req_src     = src_q[0];
    for (int i = 0; i < DEPTH; i++) begin
      if (req_oh[i]) begin
        req_payload = payload_q[i];
        req_src     = src_q[i];
      end
    end
  end

  // A result broadcast in the dispatch cycle would otherwise be missed.
  always_comb begin
    disp_entry      = disp_src;
    disp_entry.rdy1 = disp_src.rdy1 | wb_hit(disp_src.tag1, wb);
    disp_entry.rdy2 = disp_src.rdy2 | wb_hit(disp_src.tag2, wb);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;  // Exception or trap return drops everything.
    end else begin
      busy <= (busy & ~(req_oh & {DEPTH{grant}})) | (free_oh & {DEPTH{disp_valid}});
    end
  end

  // Entry contents; an entry only counts while busy.
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (disp_valid && free_oh[i]) begin
        payload_q[i] <= disp_payload;
        src_q[i]     <= disp_entry;
      end else if (busy[i]) begin
        if (wb_hit(src_q[i].tag1, wb)) begin
          src_q[i].rdy1 <= 1'b1;
        end
        if (wb_hit(src_q[i].tag2, wb)) begin
          src_q[i].rdy2 <= 1'b1;
        end
      end
    end
  end

  // Dispatch relies on the full flag seen by rename.
  a_no_disp_full: assert property (
    @(posedge clk) disable iff (!arst_n) disp_valid |-> !full
  ) else $error("dispatch into full station");

  // The arbiter may only grant a station that is asking.
  a_grant_has_req: assert property (
    @(posedge clk) disable iff (!arst_n) grant |-> req
  ) else $error("grant without request");

endmodule

//--- src/issue_arbiter.sv
`timescale 1ns/1ps

module issue_arbiter (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,
  input  logic                 mul_req,
  input  rs_pkg::mul_payload_t mul_payload,
  input  rs_pkg::src_t         mul_src,
  input  logic                 div_req,
  input  rs_pkg::div_payload_t div_payload,
  input  rs_pkg::src_t         div_src,
  output logic                 mul_grant,
  output logic                 div_grant,
  output rs_pkg::issue_t       issue
);

  logic           last_mul;  // Multiply took the last grant.
  rs_pkg::issue_t issue_next;

  // Single requester wins outright, a contest goes to the other side.
  assign mul_grant = mul_req && (!div_req || !last_mul);
  assign div_grant = div_req && (!mul_req || last_mul);

  always_comb begin
    issue_next = '0;
    if (mul_grant) begin
      issue_next.valid  = 1'b1;
      issue_next.unit   = 1'b0;
      issue_next.pc     = mul_payload.pc;
      issue_next.rd     = mul_payload.rd;
      issue_next.op     = mul_payload.op;
      issue_next.flag_a = mul_payload.high;
      issue_next.flag_b = 1'b0;
      issue_next.src1   = mul_src.tag1;
      issue_next.src2   = mul_src.tag2;
    end else if (div_grant) begin
      issue_next.valid  = 1'b1;
      issue_next.unit   = 1'b1;
      issue_next.pc     = div_payload.pc;
      issue_next.rd     = div_payload.rd;
      issue_next.op     = div_payload.op;
      issue_next.flag_a = div_payload.is_signed;
      issue_next.flag_b = div_payload.rem;
      issue_next.src1   = div_src.tag1;
      issue_next.src2   = div_src.tag2;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_mul <= 1'b0;
      issue    <= '0;
    end else if (flush) begin
      issue.valid <= 1'b0;  // Flushed grant is dropped, priority kept.
    end else begin
      if (mul_grant || div_grant) begin
        last_mul <= mul_grant;
      end
      issue <= issue_next;
    end
  end

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (!arst_n) !(mul_grant && div_grant)
  ) else $error("both stations granted");

endmodule

//--- src/rs_cluster.sv
`timescale 1ns/1ps

module rs_cluster (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 mul_disp_valid,
  input  rs_pkg::mul_payload_t mul_disp_payload,
  input  rs_pkg::src_t         mul_disp_src,
  input  logic                 div_disp_valid,
  input  rs_pkg::div_payload_t div_disp_payload,
  input  rs_pkg::src_t         div_disp_src,
  input  rs_pkg::wb_bus_t      wb,
  input  logic                 flush,
  output logic                 mul_full,
  output logic                 div_full,
  output rs_pkg::issue_t       issue
);

  logic                 mul_req;
  rs_pkg::mul_payload_t mul_req_payload;
  rs_pkg::src_t         mul_req_src;
  logic                 mul_grant;

  logic                 div_req;
  rs_pkg::div_payload_t div_req_payload;
  rs_pkg::src_t         div_req_src;
  logic                 div_grant;

  reservation_station #(
    .payload_t (rs_pkg::mul_payload_t)
  ) u_mul_rs (
    .clk          (clk),
    .arst_n       (arst_n),
    .flush        (flush),
    .disp_valid   (mul_disp_valid),
    .disp_payload (mul_disp_payload),
    .disp_src     (mul_disp_src),
    .wb           (wb),
    .full         (mul_full),
    .req          (mul_req),
    .req_payload  (mul_req_payload),
    .req_src      (mul_req_src),
    .grant        (mul_grant)
  );

  reservation_station #(
    .payload_t (rs_pkg::div_payload_t)
  ) u_div_rs (
    .clk          (clk),
    .arst_n       (arst_n),
    .flush        (flush),
    .disp_valid   (div_disp_valid),
    .disp_payload (div_disp_payload),
    .disp_src     (div_disp_src),
    .wb           (wb),
    .full         (div_full),
    .req          (div_req),
    .req_payload  (div_req_payload),
    .req_src      (div_req_src),
    .grant        (div_grant)
  );

  // One issue slot per cycle into the shared mul/div unit.
  issue_arbiter u_arbiter (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .mul_req     (mul_req),
    .mul_payload (mul_req_payload),
    .mul_src     (mul_req_src),
    .div_req     (div_req),
    .div_payload (div_req_payload),
    .div_src     (div_req_src),
    .mul_grant   (mul_grant),
    .div_grant   (div_grant),
    .issue       (issue)
  );

endmodule

//--- test/rs_model.svh
`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

// One station entry as the model sees it, op.unit names the station.
typedef struct packed {
  logic           busy;
  logic           r1;
  logic           r2;
  rs_pkg::issue_t op;
} model_entry_t;

model_entry_t   m_rs [2][rs_pkg::RS_DEPTH];
model_entry_t   m_disp [2];  // Dispatch driven in the current cycle.
logic           m_last_mul;
rs_pkg::issue_t m_issue;     // Expected issue after the coming edge.
logic [1:0]     m_full;

function automatic logic on_bus(input rs_pkg::tag_t tag, input rs_pkg::wb_bus_t bus);
  logic seen;
  seen = 1'b0;
  for (int p = 0; p < rs_pkg::NUM_WB; p++) begin
    if (bus[p].valid && bus[p].tag == tag) begin
      seen = 1'b1;
    end
  end
  return seen;
endfunction

// Moves the model across one clock edge.
task automatic model_step(input logic fl, input rs_pkg::wb_bus_t bus);
  int sel [2];
  int slot [2];
  int win;
  win = -1;
  for (int s = 0; s < 2; s++) begin
    sel[s]  = -1;
    slot[s] = -1;
    for (int i = rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
      if (m_rs[s][i].busy && m_rs[s][i].r1 && m_rs[s][i].r2) begin
        sel[s] = i;
      end
      if (!m_rs[s][i].busy) begin
        slot[s] = i;
      end
    end
  end
  if (sel[0] >= 0 && sel[1] >= 0) begin
    win = m_last_mul ? 1 : 0;  // Contest goes to the other station.
  end else if (sel[0] >= 0 || sel[1] >= 0) begin
    win = (sel[0] >= 0) ? 0 : 1;
  end
  if (fl) begin
    m_issue.valid = 1'b0;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
        m_rs[s][i].busy = 1'b0;
      end
    end
  end else begin
    m_issue = '0;
    if (win >= 0) begin
      m_issue    = m_rs[win][sel[win]].op;
      m_last_mul = (win == 0);
      m_rs[win][sel[win]].busy = 1'b0;
    end
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
        if (m_rs[s][i].busy) begin
          m_rs[s][i].r1 |= on_bus(m_rs[s][i].op.src1, bus);
          m_rs[s][i].r2 |= on_bus(m_rs[s][i].op.src2, bus);
        end
      end
      if (m_disp[s].busy && slot[s] >= 0) begin
        m_rs[s][slot[s]] = m_disp[s];
        m_rs[s][slot[s]].r1 |= on_bus(m_disp[s].op.src1, bus);
        m_rs[s][slot[s]].r2 |= on_bus(m_disp[s].op.src2, bus);
      end
    end
  end
  for (int s = 0; s < 2; s++) begin
    m_full[s] = 1'b1;
    for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
      if (!m_rs[s][i].busy) begin
        m_full[s] = 1'b0;
      end
    end
  end
endtask

task automatic model_reset();
  m_last_mul = 1'b0;
  m_issue    = '0;
  m_disp[0]  = '0;
  m_disp[1]  = '0;
  model_step(1'b1, '0);  // Flush path empties both stations.
endtask

`endif

//--- test/tb_rs_cluster.sv
`timescale 1ns/1ps

module tb_rs_cluster;

  localparam int MAX_CYCLES = 3000;

  logic                 clk;
  logic                 arst_n;
  logic                 mul_disp_valid;
  rs_pkg::mul_payload_t mul_disp_payload;
  rs_pkg::src_t         mul_disp_src;
  logic                 div_disp_valid;
  rs_pkg::div_payload_t div_disp_payload;
  rs_pkg::src_t         div_disp_src;
  rs_pkg::wb_bus_t      wb;
  logic                 flush;
  logic                 mul_full;
  logic                 div_full;
  rs_pkg::issue_t       issue;

  int cycles    = 0;
  int err_count = 0;
  int test_errs = 0;  // err_count when the running test began.
  int pass_cnt  = 0;
  int fail_cnt  = 0;

  `include "rs_model.svh"

  rs_cluster DUT (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic idle_inputs();
    mul_disp_valid   = 1'b0;
    div_disp_valid   = 1'b0;
    mul_disp_payload = '0;
    mul_disp_src     = '0;
    div_disp_payload = '0;
    div_disp_src     = '0;
    wb               = '0;
    flush            = 1'b0;
    m_disp[0]        = '0;
    m_disp[1]        = '0;
  endtask

  task automatic check_outputs();
    assert (issue.valid === m_issue.valid) else begin
      $display("FAIL issue.valid expected %h actual %h", m_issue.valid, issue.valid);
      err_count++;
    end
    if (m_issue.valid) begin
      assert (issue === m_issue) else begin
        $display("FAIL issue expected %h actual %h", m_issue, issue);
        err_count++;
      end
    end
    assert ({div_full, mul_full} === m_full) else begin
      $display("FAIL {div_full,mul_full} expected %h actual %h", m_full, {div_full, mul_full});
      err_count++;
    end
  endtask

  // One clock edge, then compare and return the inputs to idle.
  task automatic step_cycle();
    model_step(flush, wb);
    @(posedge clk);
    #1;
    check_outputs();
    idle_inputs();
  endtask

  function automatic rs_pkg::issue_t make_op(input logic unit, input logic [31:0] pc,
                                             input logic [3:0] opc, input logic [1:0] flags,
                                             input int rd, input int s1, input int s2);
    rs_pkg::issue_t o;
    o        = '0;
    o.unit   = unit;
    o.pc     = pc;
    o.op     = opc;
    o.flag_a = flags[1];
    o.flag_b = unit & flags[0];  // Multiply carries no second flag.
    o.rd     = rs_pkg::tag_t'(rd);
    o.src1   = rs_pkg::tag_t'(s1);
    o.src2   = rs_pkg::tag_t'(s2);
    return o;
  endfunction

  task automatic dispatch(input rs_pkg::issue_t o, input logic r1, input logic r2);
    o.valid = 1'b1;
    if (o.unit) begin
      div_disp_valid   = 1'b1;
      div_disp_payload = '{pc: o.pc, rd: o.rd, op: o.op, is_signed: o.flag_a, rem: o.flag_b};
      div_disp_src     = '{tag1: o.src1, rdy1: r1, tag2: o.src2, rdy2: r2};
    end else begin
      mul_disp_valid   = 1'b1;
      mul_disp_payload = '{pc: o.pc, rd: o.rd, op: o.op, high: o.flag_a};
      mul_disp_src     = '{tag1: o.src1, rdy1: r1, tag2: o.src2, rdy2: r2};
    end
    m_disp[o.unit] = '{busy: 1'b1, r1: r1, r2: r2, op: o};
  endtask

  task automatic broadcast(input int port, input int tag);
    wb[port] = '{valid: 1'b1, tag: rs_pkg::tag_t'(tag)};
  endtask

  task automatic expect_issue(input rs_pkg::issue_t o);
    o.valid = 1'b1;
    assert (issue === o) else begin
      $display("FAIL issue expected %h actual %h", o, issue);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_errs) begin
      pass_cnt++;
      $display("test %s ok", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, err_count - test_errs);
    end
    test_errs = err_count;
  endtask

  initial begin
    rs_pkg::issue_t a;
    rs_pkg::issue_t b;
    rs_pkg::issue_t mq [$];
    rs_pkg::issue_t dq [$];
    logic [31:0]    r;
    void'($urandom(1256));
    arst_n = 1'b0;
    idle_inputs();
    model_reset();
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_outputs();

    a = make_op(1'b0, 32'h0000_1000, 4'h3, 2'b10, 'h21, 'h05, 'h06);
    dispatch(a, 1'b1, 1'b1);
    step_cycle();
    step_cycle();
    expect_issue(a);
    finish_test("mul_issue");

    for (int p = 0; p < rs_pkg::NUM_WB; p++) begin
      a = make_op(1'b1, 32'h2000 + p * 4, 4'h5, 2'b11, 'h30 + p, 'h10, 'h11 + p);
      dispatch(a, 1'b1, 1'b0);
      step_cycle();
      broadcast(p, 'h20);  // Unrelated tag.
      step_cycle();
      step_cycle();
      assert (!issue.valid) else begin
        $display("operation issued while a source was still waiting");
        err_count++;
      end
      broadcast(p, 'h11 + p);
      step_cycle();
      step_cycle();
      expect_issue(a);
    end
    finish_test("wakeup");

    a = make_op(1'b0, 32'h3000, 4'h1, 2'b00, 'h40, 'h41, 'h42);
    dispatch(a, 1'b0, 1'b0);
    broadcast(0, 'h41);
    broadcast(2, 'h42);
    step_cycle();
    step_cycle();
    expect_issue(a);
    finish_test("bypass");

    for (int i = 0; i < 3; i++) begin
      a = make_op(1'b0, 32'h4000 + i * 4, 4'h2, 2'b10, 'h50 + i, 'h60, 'h61);
      b = make_op(1'b1, 32'h4100 + i * 4, 4'h6, 2'b01, 'h58 + i, 'h60, 'h61);
      dispatch(a, 1'b1, 1'b0);
      dispatch(b, 1'b1, 1'b0);
      mq.push_back(a);
      dq.push_back(b);
      step_cycle();
    end
    broadcast(1, 'h61);
    step_cycle();
    // Multiply took the last grant, so divide leads.
    for (int i = 0; i < 6; i++) begin
      step_cycle();
      if (i % 2 == 0) begin
        expect_issue(dq.pop_front());
      end else begin
        expect_issue(mq.pop_front());
      end
    end
    finish_test("alternate");

    for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
      a = make_op(1'b0, 32'h5000 + i * 4, 4'h4, 2'b00, 'h70 + i, 'h80 + i, 'h01);
      dispatch(a, 1'b0, 1'b1);
      mq.push_back(a);
      step_cycle();
    end
    assert (mul_full) else begin
      $display("multiply station not full after filling every entry");
      err_count++;
    end
    broadcast(3, 'h83);
    step_cycle();
    step_cycle();
    expect_issue(mq[3]);
    a = make_op(1'b0, 32'h5100, 4'h7, 2'b10, 'h78, 'h90, 'h01);
    dispatch(a, 1'b0, 1'b1);
    step_cycle();
    broadcast(0, 'h90);  // Refill sits in slot 3, below entry 4.
    broadcast(1, 'h84);
    step_cycle();
    step_cycle();
    expect_issue(a);
    step_cycle();
    expect_issue(mq[4]);
    finish_test("full");

    // Both stations fill up with waiting work before the flush.
    for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
      dispatch(make_op(1'b1, 32'h6000 + i * 4, 4'h8, 2'b11, 'h90 + i, 'h91, 'h01), 1'b0, 1'b1);
      if (!m_full[0]) begin
        dispatch(make_op(1'b0, 32'h6100 + i * 4, 4'h9, 2'b00, 'h98 + i, 'h88 + i, 'h01),
                 1'b0, 1'b1);
      end
      if (i == rs_pkg::RS_DEPTH - 1) begin
        broadcast(0, 'h80);
      end
      step_cycle();
    end
    flush = 1'b1;  // Multiply entry 0 is requesting now.
    broadcast(1, 'h91);
    step_cycle();
    for (int i = 0; i < 8; i++) begin
      broadcast(i % 4, 'h80 + i);
      broadcast((i + 1) % 4, 'h91);
      step_cycle();
      assert (!issue.valid && !mul_full && !div_full) else begin
        $display("station still held work after the flush");
        err_count++;
      end
    end
    finish_test("flush");

    for (int n = 0; n < 2000; n++) begin
      r = $urandom;
      if (r[0] && !m_full[0]) begin
        dispatch(make_op(1'b0, $urandom, 4'($urandom), 2'($urandom), $urandom_range(255),
                         $urandom_range(15), $urandom_range(15)), r[2], r[3]);
      end
      if (r[1] && !m_full[1]) begin
        dispatch(make_op(1'b1, $urandom, 4'($urandom), 2'($urandom), $urandom_range(255),
                         $urandom_range(15), $urandom_range(15)), r[4], r[5]);
      end
      for (int p = 0; p < rs_pkg::NUM_WB; p++) begin
        if (r[8 + 2 * p +: 2] == 2'b00) begin
          broadcast(p, $urandom_range(15));
        end
      end
      flush = (r[31:24] == 8'h00);
      step_cycle();
    end
    finish_test("random");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+test
src/rs_pkg.sv
src/reservation_station.sv
src/issue_arbiter.sv
src/rs_cluster.sv
test/tb_rs_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rs_cluster
RTL_TOP   ?= rs_cluster
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $$(grep '^src/' $(FLIST)) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
